// File: design/fetch_pkg.sv
/*
 * fetch subsystem package
 * bus, predecode, pipeline control and decode types shared by the fetch path
 */
package fetch_pkg;

   // basic widths
   localparam int ADDR_W    = 32;
   localparam int INSN_W    = 32;
   localparam int RF_ADDR_W = 5;

   // major opcodes, insn bits 31:26
   localparam logic [5:0] OPC_J    = 6'h00;
   localparam logic [5:0] OPC_JAL  = 6'h01;
   localparam logic [5:0] OPC_BNF  = 6'h03;
   localparam logic [5:0] OPC_BF   = 6'h04;
   localparam logic [5:0] OPC_SYS  = 6'h08;
   localparam logic [5:0] OPC_RFE  = 6'h09;
   localparam logic [5:0] OPC_JR   = 6'h11;
   localparam logic [5:0] OPC_JALR = 6'h12;

   typedef logic [INSN_W-1:0] insn_t;

   // l.nop 0, opcode 0x05 with a zero immediate
   localparam insn_t NOP_WORD = 32'h1500_0000;

   // instruction bus, request side and response side
   typedef struct packed {
      logic              req;
      logic [ADDR_W-1:0] adr;
   } ibus_req_t;

   typedef struct packed {
      logic  ack;
      logic  err;
      insn_t dat;
   } ibus_rsp_t;

   // early next-pc information for the word on the bus
   typedef struct packed {
      logic              will_branch;
      logic              has_target;
      logic [ADDR_W-1:0] target;
   } predecode_t;

   // controls coming from the pipeline controller
   typedef struct packed {
      logic              padv;
      logic              branch_occur;
      logic [ADDR_W-1:0] branch_dest;
      logic              take_exception;
      logic              du_stall;
      logic              du_restart;
      logic [ADDR_W-1:0] du_restart_pc;
      logic              stepping;
      logic              execute_waiting;
      logic              flag;
      logic              flag_set;
      logic              flag_clear;
   } pipe_ctrl_t;

   typedef struct packed {
      insn_t             insn;
      logic [ADDR_W-1:0] pc;
      logic              ibus_err;
   } decode_out_t;

   typedef struct packed {
      logic [RF_ADDR_W-1:0] rfa;
      logic [RF_ADDR_W-1:0] rfb;
      logic                 re;
   } rf_read_t;

   // program load port of the instruction memory
   typedef struct packed {
      logic        we;
      logic [15:0] idx;
      insn_t       data;
   } prog_write_t;

endpackage

// File: design/branch_predecode.sv
/*
 * branch predecoder
 * classifies the acknowledged instruction word and works out the
 * early target of direct jumps and flag-resolved conditional branches
 */
`timescale 1ns/1ps

module branch_predecode
(
   input  fetch_pkg::ibus_rsp_t        rsp_i,
   input  logic [fetch_pkg::ADDR_W-1:0] pc_i,
   input  logic                         flag_i,
   input  logic                         flag_set_i,
   input  logic                         flag_clear_i,
   output fetch_pkg::predecode_t        pre_o
);

   logic [5:0]                   opcode;
   logic [fetch_pkg::ADDR_W-1:0] offset;
   logic                         bf_taken;
   logic                         bnf_taken;

   assign opcode = rsp_i.dat[31:26];

   // 26-bit word offset, sign extended and turned into a byte offset
   assign offset = {{(fetch_pkg::ADDR_W-28){rsp_i.dat[25]}}, rsp_i.dat[25:0], 2'b00};

   // set and clear from execute win over the registered flag
   assign bf_taken  = (flag_i & ~flag_clear_i) | flag_set_i;
   assign bnf_taken = ~(flag_i | flag_set_i) | flag_clear_i;

   always_comb
   begin
      // jump targets are relative to the pc of the jump itself
      pre_o.target      = pc_i + offset;
      pre_o.will_branch = 1'b0;
      pre_o.has_target  = 1'b0;
      // only a word on the bus in its ack cycle is classified
      if (rsp_i.ack)
      begin
         case (opcode)
            fetch_pkg::OPC_J,
            fetch_pkg::OPC_JAL:
            begin
               pre_o.will_branch = 1'b1;
               pre_o.has_target  = 1'b1;
            end
            // register jumps and traps, destination known later
            fetch_pkg::OPC_JR,
            fetch_pkg::OPC_JALR,
            fetch_pkg::OPC_SYS,
            fetch_pkg::OPC_RFE:
            begin
               pre_o.will_branch = 1'b1;
            end
            fetch_pkg::OPC_BF:
            begin
               pre_o.will_branch = bf_taken;
               pre_o.has_target  = bf_taken;
            end
            fetch_pkg::OPC_BNF:
            begin
               pre_o.will_branch = bnf_taken;
               pre_o.has_target  = bnf_taken;
            end
            default:
            begin
               pre_o.will_branch = 1'b0;
            end
         endcase
      end
   end

endmodule

// File: design/fetch_unit.sv
/*
 * fetch unit
 * keeps the pc, requests words on the instruction bus and registers them
 * toward decode, honouring branch, exception, debug and sleep controls
 */
`timescale 1ns/1ps

module fetch_unit
#(
   parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC = 32'h0000_0100
)
(
   input  logic                          clk,
   input  logic                          rst,
   input  fetch_pkg::pipe_ctrl_t         ctrl_i,
   input  fetch_pkg::ibus_rsp_t          rsp_i,
   input  fetch_pkg::predecode_t         pre_i,
   output fetch_pkg::ibus_req_t          req_o,
   output fetch_pkg::decode_out_t        decode_o,
   output fetch_pkg::rf_read_t           rf_o,
   output logic                          fetch_ready_o,
   output logic                          fetch_sleep_o,
   output logic [fetch_pkg::ADDR_W-1:0]  pc_fetch_o
);

   logic [fetch_pkg::ADDR_W-1:0] pc;
   logic [fetch_pkg::ADDR_W-1:0] pc_next;
   logic                         fetch_req;
   logic                         jump_in_decode;
   logic                         took_early;
   logic                         padv_r;
   logic                         took_branch;
   logic                         sleep;
   logic                         advance;
   logic                         padv_deasserted;
   logic                         will_sleep;
   fetch_pkg::insn_t             dec_insn;
   logic [fetch_pkg::ADDR_W-1:0] dec_pc;
   logic                         dec_err;

   // word accepted this cycle
   assign advance = rsp_i.ack & (ctrl_i.padv | ctrl_i.stepping);
   assign pc_next = pre_i.has_target ? pre_i.target : pc + fetch_pkg::ADDR_W'(4);

   // a direct jump whose target is its own pc
   assign will_sleep = pre_i.has_target & (pre_i.target == pc);

   // padv fell on us for a reason other than a branch, so refetch
   assign padv_deasserted = padv_r & ~ctrl_i.padv & fetch_req & ~took_branch;

   // execute_waiting cuts req right away, the register catches up a cycle later
   assign req_o.req = fetch_req & ~ctrl_i.take_exception
                      & ~(ctrl_i.execute_waiting & fetch_req);
   assign req_o.adr = pc;

   assign fetch_ready_o = rsp_i.ack | jump_in_decode;
   assign fetch_sleep_o = sleep;
   assign pc_fetch_o    = pc;

   // register file read straight off the bus word
   assign rf_o = '{rfa: rsp_i.dat[20:16], rfb: rsp_i.dat[15:11], re: advance};

   assign decode_o = '{insn: dec_insn, pc: dec_pc, ibus_err: dec_err};

   // pc, advance first, then branch, exception and debug restart
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc     <= RESET_PC;
         dec_pc <= RESET_PC;
      end
      else if (advance)
      begin
         pc     <= pc_next;
         dec_pc <= pc;
      end
      else if (ctrl_i.branch_occur & ~took_early)
         pc <= ctrl_i.branch_dest;
      else if (ctrl_i.take_exception & ~ctrl_i.du_stall)
         pc <= ctrl_i.branch_dest;
      else if (ctrl_i.du_restart)
         pc <= ctrl_i.du_restart_pc;
      else if (ctrl_i.take_exception & ctrl_i.du_stall)
         pc <= ctrl_i.du_restart_pc;
   end

   // instruction toward decode, nop whenever nothing valid is there
   always_ff @(posedge clk)
   begin
      if (rst)
         dec_insn <= fetch_pkg::NOP_WORD;
      else if (sleep | ctrl_i.du_stall)
         dec_insn <= fetch_pkg::NOP_WORD;
      else if (advance & ~padv_deasserted)
         dec_insn <= rsp_i.dat;
      else if (ctrl_i.branch_occur & ctrl_i.padv)
         dec_insn <= fetch_pkg::NOP_WORD;
      else if (ctrl_i.take_exception)
         dec_insn <= fetch_pkg::NOP_WORD;
   end

   // bus request, high unless one of the drop causes holds
   always_ff @(posedge clk)
   begin
      if (rst)
         fetch_req <= 1'b1;
      else if (fetch_req & ctrl_i.stepping & rsp_i.ack)
         fetch_req <= 1'b0;
      else if (~fetch_req & ctrl_i.du_stall)
         fetch_req <= 1'b0;
      else if (rsp_i.err | sleep | pre_i.will_branch)
         fetch_req <= 1'b0;
      else if (ctrl_i.execute_waiting | padv_deasserted)
         fetch_req <= 1'b0;
      else
         fetch_req <= 1'b1;
   end

   // branch bookkeeping, one cycle pulses after a branch-class word
   always_ff @(posedge clk)
   begin
      if (rst | sleep)
      begin
         jump_in_decode <= 1'b0;
         took_early     <= 1'b0;
      end
      else
      begin
         jump_in_decode <= ~jump_in_decode & pre_i.will_branch & rsp_i.ack;
         took_early     <= pre_i.will_branch & pre_i.has_target & ctrl_i.padv;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         padv_r      <= 1'b0;
         took_branch <= 1'b0;
      end
      else
      begin
         padv_r      <= ctrl_i.padv;
         took_branch <= ctrl_i.branch_occur & fetch_ready_o;
      end
   end

   // bus error travels with the word it belongs to
   always_ff @(posedge clk)
   begin
      if (rst)
         dec_err <= 1'b0;
      else if (((ctrl_i.padv | ctrl_i.take_exception) & ctrl_i.branch_occur)
               | ctrl_i.du_stall)
         dec_err <= 1'b0;
      else if (fetch_req)
         dec_err <= rsp_i.err;
   end

   // sleep holds until an exception wakes the core
   always_ff @(posedge clk)
   begin
      if (rst)
         sleep <= 1'b0;
      else if (ctrl_i.take_exception)
         sleep <= 1'b0;
      else if (will_sleep)
         sleep <= 1'b1;
   end

endmodule

// File: design/insn_memory.sv
/*
 * instruction memory
 * word array on the req/ack instruction bus with programmable wait states,
 * a single-cycle load port and an error answer for out-of-range addresses
 */
`timescale 1ns/1ps

module insn_memory
#(
   parameter int MEM_WORDS   = 256,
   parameter int WAIT_STATES = 1
)
(
   input  logic                   clk,
   input  logic                   rst,
   input  fetch_pkg::ibus_req_t   req_i,
   input  fetch_pkg::prog_write_t load_i,
   output fetch_pkg::ibus_rsp_t   rsp_o
);

   localparam int IDX_W = $clog2(MEM_WORDS);
   localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

   fetch_pkg::insn_t             mem [MEM_WORDS];
   logic [fetch_pkg::ADDR_W-1:0] adr_q;
   logic                         req_q;
   logic                         done_q;
   logic [CNT_W-1:0]             cnt_q;
   logic [CNT_W-1:0]             cnt;
   logic                         same;
   logic                         fire;
   logic                         in_range;
   logic [IDX_W-1:0]             rd_idx;

   // request still running on the address seen last cycle
   assign same = req_q & req_i.req & (req_i.adr == adr_q);
   // a new request counts from zero in its first cycle
   assign cnt  = same ? cnt_q : '0;

   assign in_range = req_i.adr < fetch_pkg::ADDR_W'(MEM_WORDS * 4);
   assign rd_idx   = req_i.adr[IDX_W+1:2];

   // one answer per address, once the wait states have gone by
   assign fire = req_i.req & ~(same & done_q) & (cnt == CNT_W'(WAIT_STATES));

   assign rsp_o.ack = fire & in_range;
   assign rsp_o.err = fire & ~in_range;
   assign rsp_o.dat = rsp_o.ack ? mem[rd_idx] : '0;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         req_q  <= 1'b0;
         done_q <= 1'b0;
         cnt_q  <= '0;
      end
      else
      begin
         req_q  <= req_i.req;
         done_q <= req_i.req & ((same & done_q) | fire);
         // saturate at the wait count
         cnt_q  <= (cnt == CNT_W'(WAIT_STATES)) ? cnt : cnt + CNT_W'(1);
      end
   end

   always_ff @(posedge clk)
   begin
      adr_q <= req_i.adr;
   end

   // program load, writes past the end are ignored
   always_ff @(posedge clk)
   begin
      if (load_i.we && (load_i.idx < 16'(MEM_WORDS)))
         mem[load_i.idx[IDX_W-1:0]] <= load_i.data;
   end

endmodule

// File: design/fetch_subsys.sv
/*
 * fetch subsystem top
 * fetch unit, branch predecoder and wait-state instruction memory
 */
`timescale 1ns/1ps

module fetch_subsys
#(
   parameter logic [fetch_pkg::ADDR_W-1:0] RESET_PC    = 32'h0000_0100,
   parameter int                           MEM_WORDS   = 256,
   parameter int                           WAIT_STATES = 1
)
(
   input  logic                         clk,
   input  logic                         rst,
   input  fetch_pkg::pipe_ctrl_t        pipe_ctrl_i,
   input  fetch_pkg::prog_write_t       prog_load_i,
   output fetch_pkg::decode_out_t       decode_o,
   output fetch_pkg::rf_read_t          rf_o,
   output logic                         fetch_ready_o,
   output logic                         fetch_sleep_o,
   output logic [fetch_pkg::ADDR_W-1:0] pc_fetch_o
);

   fetch_pkg::ibus_req_t  ibus_req;
   fetch_pkg::ibus_rsp_t  ibus_rsp;
   fetch_pkg::predecode_t pre;

   fetch_unit #(.RESET_PC(RESET_PC)) i_fetch (
      .clk           (clk),
      .rst           (rst),
      .ctrl_i        (pipe_ctrl_i),
      .rsp_i         (ibus_rsp),
      .pre_i         (pre),
      .req_o         (ibus_req),
      .decode_o      (decode_o),
      .rf_o          (rf_o),
      .fetch_ready_o (fetch_ready_o),
      .fetch_sleep_o (fetch_sleep_o),
      .pc_fetch_o    (pc_fetch_o)
   );

   // predecode sees the bus word against the pc it was fetched from
   branch_predecode i_predecode (
      .rsp_i        (ibus_rsp),
      .pc_i         (pc_fetch_o),
      .flag_i       (pipe_ctrl_i.flag),
      .flag_set_i   (pipe_ctrl_i.flag_set),
      .flag_clear_i (pipe_ctrl_i.flag_clear),
      .pre_o        (pre)
   );

   insn_memory #(.MEM_WORDS(MEM_WORDS), .WAIT_STATES(WAIT_STATES)) i_mem (
      .clk    (clk),
      .rst    (rst),
      .req_i  (ibus_req),
      .load_i (prog_load_i),
      .rsp_o  (ibus_rsp)
   );

endmodule

// File: tests/fetch_properties.sv
/*
 * fetch unit properties
 * request, sleep and debug stall rules checked on every fetch_unit
 */
`timescale 1ns/1ps

module fetch_properties
(
   input logic                   clk,
   input logic                   rst,
   input fetch_pkg::pipe_ctrl_t  ctrl_i,
   input fetch_pkg::ibus_rsp_t   rsp_i,
   input fetch_pkg::predecode_t  pre_i,
   input fetch_pkg::ibus_req_t   req_o,
   input fetch_pkg::decode_out_t decode_o,
   input logic                   fetch_sleep_o
);

   // a branch-class word on the bus leaves one idle cycle on req
   a_req_drop_after_branch: assert property (@(posedge clk) disable iff (rst)
      (rsp_i.ack && pre_i.will_branch) |=> !req_o.req)
      else $error("req still high in the cycle after a branch-class ack");

   // only an exception wakes the unit up
   a_sleep_holds: assert property (@(posedge clk) disable iff (rst)
      (fetch_sleep_o && !ctrl_i.take_exception) |=> fetch_sleep_o)
      else $error("sleep cleared without take_exception");

   // debug stall puts a nop in front of decode
   a_stall_nop: assert property (@(posedge clk) disable iff (rst)
      ctrl_i.du_stall |=> (decode_o.insn == fetch_pkg::NOP_WORD))
      else $error("decode insn is not a nop after du_stall");

endmodule

bind fetch_unit fetch_properties i_props (
   .clk           (clk),
   .rst           (rst),
   .ctrl_i        (ctrl_i),
   .rsp_i         (rsp_i),
   .pre_i         (pre_i),
   .req_o         (req_o),
   .decode_o      (decode_o),
   .fetch_sleep_o (fetch_sleep_o)
);

// File: tests/tb_fetch_subsys.sv
/*
 * fetch subsystem testbench
 * acts as pipeline controller, loads programs and checks the words reaching decode
 */
`timescale 1ns/1ps

module tb_fetch_subsys;

   localparam logic [31:0] RESET_PC    = 32'h0000_0100;
   localparam int          MEM_WORDS   = 256;
   localparam int          WAIT_STATES = 1;
   // every reset-and-run counts as one test for the watchdog
   localparam int          NUM_RUNS    = 12;
   localparam int          WATCHDOG_NS = NUM_RUNS * 200 * (WAIT_STATES + 1) * 10;
   localparam int          WAIT_LIMIT  = 60 * (WAIT_STATES + 1);

   logic                   clk;
   logic                   rst;
   fetch_pkg::pipe_ctrl_t  ctrl;
   fetch_pkg::prog_write_t load;
   fetch_pkg::decode_out_t decode;
   fetch_pkg::rf_read_t    rf;
   logic                   ready;
   logic                   sleep;
   logic [31:0]            pc_fetch;

   // reference copy of the program memory
   fetch_pkg::insn_t       model [MEM_WORDS];
   int                     stage_idx [$];
   fetch_pkg::insn_t       stage_dat [$];
   // accepted words, in order, and the rf read seen with each
   fetch_pkg::decode_out_t got [$];
   fetch_pkg::rf_read_t    rf_got [$];
   fetch_pkg::rf_read_t    rf_d;
   logic                   take_d;
   int                     errors;
   int                     checks;

   fetch_subsys #(
      .RESET_PC    (RESET_PC),
      .MEM_WORDS   (MEM_WORDS),
      .WAIT_STATES (WAIT_STATES)
   ) i_dut (
      .clk           (clk),
      .rst           (rst),
      .pipe_ctrl_i   (ctrl),
      .prog_load_i   (load),
      .decode_o      (decode),
      .rf_o          (rf),
      .fetch_ready_o (ready),
      .fetch_sleep_o (sleep),
      .pc_fetch_o    (pc_fetch)
   );

   always #5 clk = ~clk;

   // end the run if the tests get stuck
   initial
   begin
      #(WATCHDOG_NS);
      $display("watchdog expired before all tests finished");
      $display("Simulation FAILED");
      $finish;
   end

   // an ack accepted this cycle shows up in the decode register next cycle
   always @(negedge clk)
   begin
      if (take_d)
      begin
         got.push_back(decode);
         rf_got.push_back(rf_d);
      end
      take_d = ~rst & rf.re & ready;
      rf_d   = rf;
   end

   function automatic fetch_pkg::pipe_ctrl_t idle_ctrl();
      fetch_pkg::pipe_ctrl_t c;
      c      = '0;
      c.padv = 1'b1;
      return c;
   endfunction

   // next pc from the early branch rules
   function automatic logic [31:0] next_pc(input logic [31:0] pc, input fetch_pkg::insn_t w);
      logic [5:0]  op;
      logic [31:0] tgt;
      logic        fl;
      op  = w[31:26];
      tgt = pc + {{4{w[25]}}, w[25:0], 2'b00};
      fl  = ctrl.flag_set ? 1'b1 : (ctrl.flag_clear ? 1'b0 : ctrl.flag);
      if (op == fetch_pkg::OPC_J || op == fetch_pkg::OPC_JAL)
         return tgt;
      if ((op == fetch_pkg::OPC_BF && fl) || (op == fetch_pkg::OPC_BNF && !fl))
         return tgt;
      return pc + 32'd4;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic check_decode(input string name, input fetch_pkg::decode_out_t exp,
                               input fetch_pkg::decode_out_t act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("error %s: expected insn %h pc %h err %b, actual insn %h pc %h err %b",
                  name, exp.insn, exp.pc, exp.ibus_err, act.insn, act.pc, act.ibus_err);
      end
   endtask

   task automatic check_rf(input string name, input fetch_pkg::rf_read_t exp,
                           input fetch_pkg::rf_read_t act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("error %s: expected rfa %0d rfb %0d re %b, actual rfa %0d rfb %0d re %b",
                  name, exp.rfa, exp.rfb, exp.re, act.rfa, act.rfb, act.re);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("error %s: expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic check_pc(input string name, input logic [fetch_pkg::ADDR_W-1:0] exp,
                           input logic [fetch_pkg::ADDR_W-1:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("error %s: expected pc %h actual pc %h", name, exp, act);
      end
   endtask

   task automatic stage(input int idx, input fetch_pkg::insn_t w);
      stage_idx.push_back(idx);
      stage_dat.push_back(w);
   endtask

   // random alu filler, opcode 0x38
   task automatic stage_alu(input int first, input int n);
      for (int i = 0; i < n; i++)
         stage(first + i, {6'h38, 26'($urandom)});
   endtask

   // program load under reset, then 5 more reset cycles
   task automatic restart_dut(input fetch_pkg::pipe_ctrl_t c);
      rst  = 1'b1;
      ctrl = c;
      foreach (stage_idx[i])
      begin
         next_cycle();
         load = '{we: 1'b1, idx: 16'(stage_idx[i]), data: stage_dat[i]};
         model[stage_idx[i]] = stage_dat[i];
      end
      next_cycle();
      load.we = 1'b0;
      repeat (5) next_cycle();
      rst = 1'b0;
      got.delete();
      rf_got.delete();
      stage_idx.delete();
      stage_dat.delete();
   endtask

   task automatic wait_decodes(input string name, input int n);
      int cyc;
      cyc = 0;
      while (got.size() < n && cyc < WAIT_LIMIT)
      begin
         @(posedge clk);
         cyc++;
      end
      if (got.size() < n)
      begin
         errors++;
         $display("error %s: only %0d of %0d words reached decode", name, got.size(), n);
      end
   endtask

   // i-th accepted word must be the program word at pc
   task automatic expect_at(input string name, input int i, input logic [31:0] pc);
      wait_decodes(name, i + 1);
      if (got.size() > i)
         check_decode(name, '{insn: model[(pc >> 2) % MEM_WORDS], pc: pc, ibus_err: 1'b0},
                      got[i]);
   endtask

   task automatic expect_walk(input string name, input logic [31:0] start, input int n);
      logic [31:0] pc;
      pc = start;
      for (int i = 0; i < n; i++)
      begin
         expect_at(name, i, pc);
         pc = next_pc(pc, model[(pc >> 2) % MEM_WORDS]);
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      $display("test %s: %s", name, (errors == err_before) ? "ok" : "mismatch");
   endtask

   task automatic test_sequential();
      int e;
      e = errors;
      stage_alu(64, 16);
      restart_dut(idle_ctrl());
      expect_walk("sequential", RESET_PC, 8);
      for (int i = 0; i < 8 && i < rf_got.size(); i++)
         check_rf("sequential rf", '{rfa: model[64 + i][20:16], rfb: model[64 + i][15:11],
                  re: 1'b1}, rf_got[i]);
      report_test("sequential", e);
   endtask

   task automatic test_jumps();
      int e;
      int cyc;
      e = errors;
      // direct jump, target is its own pc + 20
      stage(64, {fetch_pkg::OPC_J, 26'd5});
      stage_alu(65, 12);
      restart_dut(idle_ctrl());
      expect_walk("jump", RESET_PC, 3);
      // register jump resolved by the controller
      stage(64, {fetch_pkg::OPC_JR, 26'd0});
      stage_alu(65, 4);
      stage_alu(96, 4);
      restart_dut(idle_ctrl());
      cyc = 0;
      do
      begin
         @(negedge clk);
         cyc++;
      end
      while (!(rf.re && pc_fetch == RESET_PC) && cyc < WAIT_LIMIT);
      @(posedge clk);
      #1;
      ctrl.branch_occur = 1'b1;
      ctrl.branch_dest  = 32'h180;
      next_cycle();
      ctrl.branch_occur = 1'b0;
      expect_at("jr", 0, RESET_PC);
      expect_at("jr", 1, 32'h180);
      expect_at("jr", 2, 32'h184);
      report_test("jumps", e);
   endtask

   task automatic cond_case(input string name, input fetch_pkg::insn_t w,
                            input logic fl, input logic set, input logic clr);
      fetch_pkg::pipe_ctrl_t c;
      int                    e;
      e            = errors;
      c            = idle_ctrl();
      c.flag       = fl;
      c.flag_set   = set;
      c.flag_clear = clr;
      stage(64, w);
      stage_alu(65, 8);
      restart_dut(c);
      expect_walk(name, RESET_PC, 2);
      report_test(name, e);
   endtask

   task automatic test_sleep();
      int e;
      int cyc;
      e = errors;
      stage(64, {fetch_pkg::OPC_J, 26'd0});
      stage_alu(65, 4);
      stage_alu(96, 4);
      restart_dut(idle_ctrl());
      expect_at("sleep", 0, RESET_PC);
      cyc = 0;
      while (!sleep && cyc < WAIT_LIMIT)
      begin
         @(negedge clk);
         cyc++;
      end
      check_flag("sleep set", 1'b1, sleep);
      repeat (10) next_cycle();
      check_flag("no fetch while asleep", 1'b1, got.size() == 1);
      check_flag("no ready while asleep", 1'b0, ready);
      // a jump-to-self leaves the fetch pc on the jump
      check_pc("pc while asleep", RESET_PC, pc_fetch);
      ctrl.take_exception = 1'b1;
      ctrl.branch_dest    = 32'h180;
      next_cycle();
      ctrl.take_exception = 1'b0;
      check_flag("sleep cleared", 1'b0, sleep);
      expect_at("wake", 1, 32'h180);
      report_test("sleep", e);
   endtask

   task automatic test_bus_error();
      int   e;
      int   cyc;
      logic seen;
      e = errors;
      // 0x100 + 0x300 lands on the first address past the memory
      stage(64, {fetch_pkg::OPC_J, 26'h0c0});
      restart_dut(idle_ctrl());
      expect_at("bus error", 0, RESET_PC);
      seen = 1'b0;
      cyc  = 0;
      while (!seen && cyc < WAIT_LIMIT)
      begin
         @(negedge clk);
         seen = decode.ibus_err;
         cyc++;
      end
      check_flag("bus error flag", 1'b1, seen);
      report_test("bus error", e);
   endtask

   task automatic test_debug();
      int          e;
      int          cyc;
      int          base;
      logic [31:0] pc_hold;
      e = errors;
      stage_alu(64, 16);
      stage_alu(96, 8);
      restart_dut(idle_ctrl());
      expect_at("debug", 1, 32'h104);
      next_cycle();
      ctrl.du_stall = 1'b1;
      ctrl.padv     = 1'b0;
      next_cycle();
      // padv is low, so decode keeps the pc of the last sequential word accepted
      pc_hold = RESET_PC + 32'(4 * (got.size() - 1));
      check_decode("du_stall", '{insn: fetch_pkg::NOP_WORD, pc: pc_hold, ibus_err: 1'b0},
                   decode);
      repeat (3) next_cycle();
      ctrl.du_restart    = 1'b1;
      ctrl.du_restart_pc = 32'h180;
      next_cycle();
      ctrl.du_restart = 1'b0;
      next_cycle();
      // single step from the restart pc
      base          = got.size();
      ctrl.du_stall = 1'b0;
      ctrl.stepping = 1'b1;
      cyc           = 0;
      do
      begin
         @(negedge clk);
         cyc++;
      end
      while (!rf.re && cyc < WAIT_LIMIT);
      @(posedge clk);
      #1;
      ctrl.du_stall = 1'b1;
      ctrl.stepping = 1'b0;
      repeat (10) next_cycle();
      check_flag("one word per step", 1'b1, got.size() == base + 1);
      expect_at("step", base, 32'h180);
      ctrl.du_stall = 1'b0;
      ctrl.padv     = 1'b1;
      expect_at("resume", base + 1, 32'h184);
      report_test("debug", e);
   endtask

   initial
   begin
      clk    = 1'b0;
      rst    = 1'b1;
      ctrl   = idle_ctrl();
      load   = '0;
      take_d = 1'b0;
      rf_d   = '0;
      errors = 0;
      checks = 0;
      void'($urandom(32'hc882_dd3a));

      test_sequential();
      test_jumps();
      cond_case("bf taken", {fetch_pkg::OPC_BF, 26'd4}, 1'b1, 1'b0, 1'b0);
      cond_case("bf not taken", {fetch_pkg::OPC_BF, 26'd4}, 1'b0, 1'b0, 1'b0);
      cond_case("bnf taken", {fetch_pkg::OPC_BNF, 26'd4}, 1'b0, 1'b0, 1'b0);
      cond_case("bnf not taken", {fetch_pkg::OPC_BNF, 26'd4}, 1'b1, 1'b0, 1'b0);
      cond_case("bnf flag_clear", {fetch_pkg::OPC_BNF, 26'd4}, 1'b1, 1'b0, 1'b1);
      cond_case("bf flag_set", {fetch_pkg::OPC_BF, 26'd4}, 1'b0, 1'b1, 1'b0);
      test_sleep();
      test_bus_error();
      test_debug();

      $display("summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: fetch_subsys.f
design/fetch_pkg.sv
design/branch_predecode.sv
design/fetch_unit.sv
design/insn_memory.sv
design/fetch_subsys.sv
tests/fetch_properties.sv
tests/tb_fetch_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_fetch_subsys \
   -f fetch_subsys.f \
   -o Vtb_fetch_subsys

./obj_dir/Vtb_fetch_subsys > sim.log 2>&1
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
   exit 0
fi
exit 1
